/* logic/laneCfg.svh */
// Lane sizing macros; memory address width must cover LANE_MEM_WORDS, zero register ID must fit the ID width
`ifndef LANE_CFG_SVH
`define LANE_CFG_SVH

// Datapath width of the integer lane
`define LANE_XLEN 64

// GPR index width, 64 architectural registers
`define LANE_REG_ID_W 6

// Writes to this ID are dropped by the core
`define LANE_ZERO_REG 63

// Lane-local data memory, counted in 64-bit words
`define LANE_MEM_WORDS 64

// Word index width into the data memory
`define LANE_MEM_AW 6

`endif

/* logic/laneOpPkg.sv */
// Micro-op encodings seen by the lane; values outside laneUCmd are executed as NOP
package laneOpPkg;

	// Micro-op command after decode
	typedef enum logic [3:0] {
		opNop    = 4'd0, // No effect, still writes back
		opMovIr  = 4'd1, // Rd = sext(imm)
		opAlu3   = 4'd2, // Rd = Rs op Rt
		opAluCmp = 4'd3, // T = Rs cmp Rt, no GPR write
		opMovRm  = 4'd4, // Store, mem[Rs+imm] = Rt
		opMovMr  = 4'd5  // Load, Rd = mem[Rs+imm]
	} laneUCmd;

	// ALU sub-op, also picks the compare kind for opAluCmp
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluXor = 3'd4,
		cmpEq  = 3'd5, // Equality
		cmpGt  = 3'd6  // Signed greater-than
	} laneAluOp;

	// Predication mode evaluated against T in EX1
	typedef enum logic [1:0] {
		predAlways = 2'd0, // Always execute
		predNever  = 2'd1, // Squash to NOP
		predIfT    = 2'd2, // Execute when T set
		predIfNotT = 2'd3  // Execute when T clear
	} lanePredMode;

endpackage

/* logic/laneStagePkg.sv */
// Pipeline records between lane stages; widths come from laneCfg.svh
`include "laneCfg.svh"

package laneStagePkg;

	// Op as issued by the core
	typedef struct packed {
		laneOpPkg::laneUCmd     cmd;
		laneOpPkg::laneAluOp    aluOp;
		laneOpPkg::lanePredMode pred;
		logic [`LANE_REG_ID_W-1:0] rdId;  // Destination GPR
		logic [`LANE_XLEN-1:0]     rsVal; // Source A, ALU or base
		logic [`LANE_XLEN-1:0]     rtVal; // Source B, ALU or store data
		logic [32:0]               imm;   // Raw immediate, sign in bit 32
	} laneIssue;

	// EX1 to EX2
	typedef struct packed {
		logic                      valid;
		logic                      killed;    // Hit by a branch flush
		laneOpPkg::laneUCmd        cmd;       // Already NOP if predicated off
		logic [`LANE_REG_ID_W-1:0] rdId;
		logic [`LANE_XLEN-1:0]     result;
		logic [`LANE_MEM_AW-1:0]   memAddr;   // Word index
		logic [`LANE_XLEN-1:0]     storeData;
	} laneEx1Rec;

	// EX2 to EX3
	typedef struct packed {
		logic                      valid;
		logic                      killed;
		logic                      isLoad; // EX3 takes memory data
		logic [`LANE_REG_ID_W-1:0] rdId;
		logic [`LANE_XLEN-1:0]     result;
	} laneEx2Rec;

	// Writeback to the core
	typedef struct packed {
		logic [`LANE_REG_ID_W-1:0] rdId;
		logic [`LANE_XLEN-1:0]     value;
	} laneWb;

endpackage

/* logic/laneExec1.sv */
// EX1: predication on local T, ALU and address generation; rs+imm is a word index wrapping at memory depth
`timescale 1ns/1ps
`include "laneCfg.svh"

module laneExec1
	import laneOpPkg::*;
	import laneStagePkg::*;
(
	input  logic      clock,
	input  logic      arstN,
	input  logic      issueValid,
	input  laneIssue  issueOp,
	input  logic      braFlush,
	output laneEx1Rec ex1Out,
	output logic      tFlag
);

	logic                  tReg;           // Predicate flag
	logic                  tHist1, tHist2; // T before the last two edges, for flush rollback
	logic                  predOk;
	laneUCmd               cmdEff;
	logic [`LANE_XLEN-1:0] immExt;
	logic [`LANE_XLEN-1:0] aluRes;
	logic [`LANE_XLEN-1:0] addrSum;
	logic                  isEq, isGt, cmpBit;
	laneEx1Rec             ex1Next;

	assign tFlag  = tReg;
	assign immExt = {{(`LANE_XLEN-33){issueOp.imm[32]}}, issueOp.imm}; // Sign-extend imm33
	assign isEq   = issueOp.rsVal == issueOp.rtVal;
	assign isGt   = $signed(issueOp.rsVal) > $signed(issueOp.rtVal);
	assign addrSum = issueOp.rsVal + immExt;

	always_comb begin
		case (issueOp.pred)
			predAlways: predOk = 1'b1;
			predIfT:    predOk = tReg;
			predIfNotT: predOk = !tReg;
			default:    predOk = 1'b0; // predNever
		endcase
		cmdEff = opNop;
		if (issueValid && predOk) begin
			case (issueOp.cmd)
				opMovIr, opAlu3, opAluCmp, opMovRm, opMovMr: cmdEff = issueOp.cmd;
				default: cmdEff = opNop; // Unknown command
			endcase
		end
	end

	always_comb begin
		case (issueOp.aluOp)
			aluAdd:  aluRes = issueOp.rsVal + issueOp.rtVal;
			aluSub:  aluRes = issueOp.rsVal - issueOp.rtVal;
			aluAnd:  aluRes = issueOp.rsVal & issueOp.rtVal;
			aluOr:   aluRes = issueOp.rsVal | issueOp.rtVal;
			aluXor:  aluRes = issueOp.rsVal ^ issueOp.rtVal;
			cmpEq:   aluRes = `LANE_XLEN'(isEq);
			cmpGt:   aluRes = `LANE_XLEN'(isGt);
			default: aluRes = '0;
		endcase
		// Plain ALU sub-ops under opAluCmp test for a nonzero result
		cmpBit = (issueOp.aluOp == cmpEq) ? isEq : (issueOp.aluOp == cmpGt) ? isGt : |aluRes;
	end

	always_comb begin
		ex1Next.valid     = issueValid;
		ex1Next.killed    = braFlush;
		ex1Next.cmd       = cmdEff;
		ex1Next.rdId      = issueOp.rdId;  // NOP keeps issued Rd
		ex1Next.result    = '0;
		ex1Next.memAddr   = addrSum[`LANE_MEM_AW-1:0];
		ex1Next.storeData = issueOp.rtVal;
		case (cmdEff)
			opMovIr:  ex1Next.result = immExt;
			opAlu3:   ex1Next.result = aluRes;
			opAluCmp, opMovRm: ex1Next.rdId = `LANE_REG_ID_W'(`LANE_ZERO_REG); // No GPR write
			default:  ex1Next.result = '0; // Load data arrives in EX3
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ex1Out <= '0;
		end else begin
			ex1Out <= ex1Next;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			tReg   <= 1'b0;
			tHist1 <= 1'b0;
			tHist2 <= 1'b0;
		end else if (braFlush) begin
			tReg   <= tHist2; // Undo compares of the three killed ops
			tHist1 <= tHist2;
		end else begin
			tHist2 <= tHist1;
			tHist1 <= tReg;
			if (cmdEff == opAluCmp)
				tReg <= cmpBit; // Seen by the very next issue
		end
	end

endmodule

/* logic/laneExec2.sv */
// EX2: store write and load address toward lane memory; a flush in this cycle blocks the store
`timescale 1ns/1ps
`include "laneCfg.svh"

module laneExec2
	import laneOpPkg::*;
	import laneStagePkg::*;
(
	input  logic                    clock,
	input  logic                    arstN,
	input  logic                    braFlush,
	input  laneEx1Rec               ex1In,
	output logic                    memWe,
	output logic [`LANE_MEM_AW-1:0] memAddr,
	output logic [`LANE_XLEN-1:0]   memWdata,
	output laneEx2Rec               ex2Out
);

	logic      opLive; // Valid and not flushed, now or earlier
	laneEx2Rec ex2Next;

	assign opLive = ex1In.valid && !ex1In.killed && !braFlush;

	// Single-port memory, the same address serves load and store
	assign memWe    = opLive && (ex1In.cmd == opMovRm);
	assign memAddr  = ex1In.memAddr;
	assign memWdata = ex1In.storeData;

	always_comb begin
		ex2Next.valid  = ex1In.valid;
		ex2Next.killed = ex1In.killed || braFlush;
		ex2Next.isLoad = ex1In.cmd == opMovMr; // Read data lands with this record
		ex2Next.rdId   = ex1In.rdId;
		ex2Next.result = ex1In.result;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			ex2Out <= '0;
		end else begin
			ex2Out <= ex2Next;
		end
	end

endmodule

/* logic/laneDataMem.sv */
// Lane data memory, one port, read-before-write on a same-edge collision, contents not reset
`timescale 1ns/1ps
`include "laneCfg.svh"

module laneDataMem (
	input  logic                    clock,
	input  logic                    memWe,
	input  logic [`LANE_MEM_AW-1:0] memAddr,
	input  logic [`LANE_XLEN-1:0]   memWdata,
	output logic [`LANE_XLEN-1:0]   memRdata
);

	logic [`LANE_XLEN-1:0] memArray [`LANE_MEM_WORDS]; // Word array

	always_ff @(posedge clock) begin
		if (memWe)
			memArray[memAddr] <= memWdata;
		memRdata <= memArray[memAddr]; // One cycle read latency
	end

endmodule

/* logic/laneExec3.sv */
// EX3: final Rd and value select, writeback registered; killed ops still write back, to the zero register
`timescale 1ns/1ps
`include "laneCfg.svh"

module laneExec3
	import laneStagePkg::*;
(
	input  logic                  clock,
	input  logic                  arstN,
	input  logic                  braFlush,
	input  laneEx2Rec             ex2In,
	input  logic [`LANE_XLEN-1:0] memRdata,
	output logic                  wbValid,
	output laneWb                 wbOut
);

	laneWb wbNext;

	always_comb begin
		wbNext.rdId  = ex2In.rdId;   // Forward by default
		wbNext.value = ex2In.result;
		if (ex2In.isLoad)
			wbNext.value = memRdata; // Registered read from EX2 address
		if (ex2In.killed || braFlush)
			wbNext.rdId = `LANE_REG_ID_W'(`LANE_ZERO_REG); // Discarded by core
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			wbValid <= 1'b0;
			wbOut   <= '0;
		end else begin
			wbValid <= ex2In.valid; // Fixed 3-cycle latency
			wbOut   <= wbNext;
		end
	end

endmodule

/* logic/laneExecTop.sv */
// Integer execute lane, no stall path, writeback must be taken every cycle
`timescale 1ns/1ps
`include "laneCfg.svh"

module laneExecTop
	import laneStagePkg::*;
(
	input  logic     clock,
	input  logic     arstN,
	input  logic     issueValid,
	input  laneIssue issueOp,
	input  logic     braFlush,
	output logic     wbValid,
	output laneWb    wbOut,
	output logic     tFlag
);

	laneEx1Rec               ex1Out;
	laneEx2Rec               ex2Out;
	logic                    memWe;
	logic [`LANE_MEM_AW-1:0] memAddr;
	logic [`LANE_XLEN-1:0]   memWdata;
	logic [`LANE_XLEN-1:0]   memRdata;

	laneExec1 laneExec1_inst (
		.clock      (clock),
		.arstN      (arstN),
		.issueValid (issueValid),
		.issueOp    (issueOp),
		.braFlush   (braFlush),
		.ex1Out     (ex1Out),
		.tFlag      (tFlag)
	);

	laneExec2 laneExec2_inst (
		.clock    (clock),
		.arstN    (arstN),
		.braFlush (braFlush),
		.ex1In    (ex1Out),
		.memWe    (memWe),
		.memAddr  (memAddr),
		.memWdata (memWdata),
		.ex2Out   (ex2Out)
	);

	laneDataMem laneDataMem_inst (
		.clock    (clock),
		.memWe    (memWe),
		.memAddr  (memAddr),
		.memWdata (memWdata),
		.memRdata (memRdata)
	);

	laneExec3 laneExec3_inst (
		.clock    (clock),
		.arstN    (arstN),
		.braFlush (braFlush),
		.ex2In    (ex2Out),
		.memRdata (memRdata),
		.wbValid  (wbValid),
		.wbOut    (wbOut)
	);

endmodule

/* verif/laneExec_chk.sv */
// Timing and flush rules of laneExecTop, bound to every instance; assumes issueValid low during reset
`timescale 1ns/1ps
`include "laneCfg.svh"

module laneExecChk
	import laneStagePkg::*;
(
	input logic  clock,
	input logic  arstN,
	input logic  issueValid,
	input logic  braFlush,
	input logic  wbValid,
	input laneWb wbOut
);

	localparam logic [`LANE_REG_ID_W-1:0] zeroReg = `LANE_REG_ID_W'(`LANE_ZERO_REG);

	// No writeback while reset is held
	resetQuiet: assert property (@(posedge clock) !arstN |-> !wbValid)
		else $error("wbValid high during reset");

	// Fixed latency, every issued op returns once
	fixedLatency: assert property (@(posedge clock) disable iff (!arstN)
		wbValid == $past(issueValid, 3))
		else $error("wbValid does not follow issueValid by 3 cycles");

	// Flushed op goes to the zero register
	flushKill: assert property (@(posedge clock) disable iff (!arstN)
		wbValid && $past(braFlush, 2) |-> wbOut.rdId == zeroReg)
		else $error("flushed op wrote back to rdId %0d", wbOut.rdId);

endmodule

bind laneExecTop laneExecChk laneExecChk_inst (
	.clock      (clock),
	.arstN      (arstN),
	.issueValid (issueValid),
	.braFlush   (braFlush),
	.wbValid    (wbValid),
	.wbOut      (wbOut)
);

/* verif/laneExecTb.sv */
// Directed testbench for laneExecTop; writeback expected 3 edges after the drive edge, lane memory never reset
`timescale 1ns/1ps
`include "laneCfg.svh"

module laneExecTb
	import laneOpPkg::*;
	import laneStagePkg::*;
();

	localparam int clockPeriod = 40;
	localparam int plannedOps = 31;   // Ops issued over all tests
	localparam int marginCycles = 80; // Reset holds, drains and idle gaps
	localparam logic [`LANE_REG_ID_W-1:0] zeroReg = `LANE_REG_ID_W'(`LANE_ZERO_REG);

	typedef struct packed {
		logic [31:0]               due;    // Negedge count at which writeback shows
		logic [`LANE_REG_ID_W-1:0] rdId;
		logic [`LANE_XLEN-1:0]     value;
		logic                      chkVal; // Killed ops carry a don't-care value
	} expWb;

	logic      clock;
	logic      arstN;
	logic      issueValid;
	laneIssue  issueOp;
	logic      braFlush;
	logic      wbValid;
	laneWb     wbOut;
	logic      tFlag;

	expWb                  expQ[$];       // Expected writebacks in order
	logic [31:0]           cyc;           // Negedges seen so far
	logic [63:0]           lcgState;
	logic                  modelT;        // Reference predicate flag
	logic [`LANE_XLEN-1:0] modelMem [64]; // Reference data memory
	int                    errCount;
	int                    checkCount;
	int                    testCount;
	int                    passedTests;

	laneExecTop laneExecTop_inst (
		.clock      (clock),
		.arstN      (arstN),
		.issueValid (issueValid),
		.issueOp    (issueOp),
		.braFlush   (braFlush),
		.wbValid    (wbValid),
		.wbOut      (wbOut),
		.tFlag      (tFlag)
	);

	always #(clockPeriod / 2) clock = ~clock;

	function automatic logic [63:0] nextRand();
		lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcgState;
	endfunction

	function automatic logic [63:0] signExt(input logic [32:0] imm);
		return {{31{imm[32]}}, imm};
	endfunction

	// Word index is the low address bits of base plus immediate
	function automatic logic [5:0] memIndex(input logic [63:0] rs, input logic [32:0] imm);
		logic [63:0] sum;
		sum = rs + signExt(imm);
		return sum[5:0];
	endfunction

	function automatic logic predPass(input lanePredMode pred, input logic t);
		case (pred)
			predAlways: return 1'b1;
			predIfT:    return t;
			predIfNotT: return !t;
			default:    return 1'b0;
		endcase
	endfunction

	function automatic logic [63:0] expectAlu(input laneAluOp op, input logic [63:0] a,
			input logic [63:0] b);
		case (op)
			aluAdd:  return a + b;
			aluSub:  return a - b;
			aluAnd:  return a & b;
			aluOr:   return a | b;
			aluXor:  return a ^ b;
			cmpEq:   return {63'b0, a == b};
			cmpGt:   return {63'b0, $signed(a) > $signed(b)};
			default: return '0;
		endcase
	endfunction

	function automatic laneIssue mkOp(input laneUCmd cmd, input laneAluOp aluOp,
			input lanePredMode pred, input logic [5:0] rdId, input logic [63:0] rsVal,
			input logic [63:0] rtVal, input logic [32:0] imm);
		laneIssue op;
		op.cmd   = cmd;
		op.aluOp = aluOp;
		op.pred  = pred;
		op.rdId  = rdId;
		op.rsVal = rsVal;
		op.rtVal = rtVal;
		op.imm   = imm;
		return op;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errCount++;
			$display("FAILED at %0d ns: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	// Drive one op for one edge and queue its writeback
	task automatic sendOp(input laneIssue op, input logic flush, input logic [5:0] expRd,
			input logic [63:0] expVal, input logic chkVal);
		@(posedge clock);
		issueValid <= 1'b1;
		issueOp    <= op;
		braFlush   <= flush;
		expQ.push_back('{due: cyc + 32'd3, rdId: expRd, value: expVal, chkVal: chkVal});
	endtask

	task automatic drain();
		int waitCycles;
		@(posedge clock);
		issueValid <= 1'b0;
		braFlush   <= 1'b0;
		waitCycles = 0;
		while (expQ.size() != 0 && waitCycles < 8) begin
			@(posedge clock);
			waitCycles++;
		end
		if (expQ.size() != 0) begin
			errCount++;
			$display("Writeback missing: %0d expected ops never came back", expQ.size());
			expQ.delete();
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore) begin
			passedTests++;
			$display("Test %s: passed", name);
		end else begin
			$display("Test %s: failed with %0d errors", name, errCount - errBefore);
		end
	endtask

	task automatic testAlu();
		laneAluOp    ops [5];
		logic [63:0] rs, rt;
		logic [32:0] imm;
		int          errBefore;
		errBefore = errCount;
		ops = '{aluAdd, aluSub, aluAnd, aluOr, aluXor};
		imm = 33'(nextRand());
		sendOp(mkOp(opMovIr, aluAdd, predAlways, 6'd1, '0, '0, imm), 1'b0, 6'd1, signExt(imm), 1'b1);
		for (int i = 0; i < 5; i++) begin // Back to back, three in flight
			rs = nextRand();
			rt = nextRand();
			sendOp(mkOp(opAlu3, ops[i], predAlways, 6'(i + 2), rs, rt, '0), 1'b0, 6'(i + 2),
				expectAlu(ops[i], rs, rt), 1'b1);
		end
		drain();
		reportTest("immediate and ALU", errBefore);
	endtask

	task automatic testPred();
		logic [63:0] rs, rt;
		logic [32:0] imm;
		int          errBefore;
		errBefore = errCount;
		rs = nextRand();
		sendOp(mkOp(opAluCmp, cmpEq, predAlways, 6'd5, rs, rs, '0), 1'b0, zeroReg, '0, 1'b1);
		modelT = 1'b1; // Equal operands
		imm = 33'(nextRand());
		sendOp(mkOp(opMovIr, aluAdd, predIfT, 6'd6, '0, '0, imm), 1'b0, 6'd6,
			predPass(predIfT, modelT) ? signExt(imm) : 64'd0, 1'b1);
		sendOp(mkOp(opMovIr, aluAdd, predIfNotT, 6'd7, '0, '0, imm), 1'b0, 6'd7,
			predPass(predIfNotT, modelT) ? signExt(imm) : 64'd0, 1'b1);
		sendOp(mkOp(opMovIr, aluAdd, predNever, 6'd8, '0, '0, imm), 1'b0, 6'd8, '0, 1'b1);
		rs = nextRand() >> 1;
		rt = rs + 64'd1;
		sendOp(mkOp(opAluCmp, cmpGt, predAlways, 6'd5, rs, rt, '0), 1'b0, zeroReg, '0, 1'b1);
		modelT = $signed(rs) > $signed(rt);
		sendOp(mkOp(opAlu3, aluXor, predIfNotT, 6'd9, rs, rt, '0), 1'b0, 6'd9,
			predPass(predIfNotT, modelT) ? expectAlu(aluXor, rs, rt) : 64'd0, 1'b1);
		sendOp(mkOp(opAlu3, aluSub, predIfT, 6'd10, rs, rt, '0), 1'b0, 6'd10,
			predPass(predIfT, modelT) ? expectAlu(aluSub, rs, rt) : 64'd0, 1'b1);
		drain();
		checkValue("tFlag", 64'(tFlag), 64'(modelT));
		reportTest("compare and predication", errBefore);
	endtask

	task automatic testMem();
		int          targets [3];
		logic [63:0] rs, data;
		logic [32:0] imm;
		int          errBefore;
		errBefore = errCount;
		targets = '{3, 10, 40};
		imm = 33'h1_FFFF_FFFB; // Minus 5
		for (int i = 0; i < 3; i++) begin
			data = nextRand();
			rs = (nextRand() & ~64'h3f) + 64'(targets[i]) + 64'd5;
			modelMem[memIndex(rs, imm)] = data;
			sendOp(mkOp(opMovRm, aluAdd, predAlways, 6'd11, rs, data, imm), 1'b0, zeroReg, '0, 1'b1);
		end
		for (int i = 0; i < 3; i++) begin
			sendOp(mkOp(opMovMr, aluAdd, predAlways, 6'(12 + i), 64'(targets[i]), '0, '0), 1'b0,
				6'(12 + i), modelMem[targets[i]], 1'b1);
		end
		data = nextRand();
		modelMem[50] = data; // Store then load right behind it
		sendOp(mkOp(opMovRm, aluAdd, predAlways, 6'd11, 64'd50, data, '0), 1'b0, zeroReg, '0, 1'b1);
		sendOp(mkOp(opMovMr, aluAdd, predAlways, 6'd20, 64'd50, '0, '0), 1'b0, 6'd20,
			modelMem[50], 1'b1);
		drain();
		reportTest("store and load", errBefore);
	endtask

	task automatic testFlush();
		logic [63:0] rs, rt, data;
		logic [32:0] imm;
		int          errBefore;
		errBefore = errCount;
		data = nextRand();
		modelMem[20] = data;
		sendOp(mkOp(opMovRm, aluAdd, predAlways, 6'd11, 64'd20, data, '0), 1'b0, zeroReg, '0, 1'b1);
		imm = 33'(nextRand());
		sendOp(mkOp(opMovIr, aluAdd, predAlways, 6'd13, '0, '0, imm), 1'b0, 6'd13, signExt(imm), 1'b1);
		// Three youngest below are all killed by one flush pulse
		rs = nextRand();
		rt = modelT ? ~rs : rs; // Would flip T
		sendOp(mkOp(opAluCmp, cmpEq, predAlways, 6'd5, rs, rt, '0), 1'b0, zeroReg, '0, 1'b0);
		sendOp(mkOp(opMovRm, aluAdd, predAlways, 6'd11, 64'd20, nextRand(), '0), 1'b0, zeroReg,
			'0, 1'b0); // Still in EX2 when the flush shows
		sendOp(mkOp(opMovIr, aluAdd, predAlways, 6'd14, '0, '0, imm), 1'b1, zeroReg, '0, 1'b0);
		drain();
		sendOp(mkOp(opMovMr, aluAdd, predAlways, 6'd15, 64'd20, '0, '0), 1'b0, 6'd15,
			modelMem[20], 1'b1);
		drain();
		checkValue("tFlag", 64'(tFlag), 64'(modelT));
		reportTest("flush", errBefore);
	endtask

	task automatic testReset();
		logic [63:0] rs;
		logic [32:0] imm;
		int          errBefore;
		errBefore = errCount;
		rs = nextRand();
		imm = 33'(nextRand());
		sendOp(mkOp(opAluCmp, cmpEq, predAlways, 6'd5, rs, rs, '0), 1'b0, zeroReg, '0, 1'b1);
		sendOp(mkOp(opMovIr, aluAdd, predAlways, 6'd16, '0, '0, imm), 1'b0, 6'd16, signExt(imm), 1'b1);
		sendOp(mkOp(opMovIr, aluAdd, predAlways, 6'd17, '0, '0, imm), 1'b0, 6'd17, signExt(imm), 1'b1);
		@(posedge clock);
		issueValid <= 1'b0;
		arstN      <= 1'b0; // Ops still in flight
		expQ.delete();
		modelT = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		checkValue("wbValid", 64'(wbValid), 64'd0);
		checkValue("tFlag", 64'(tFlag), 64'd0);
		@(posedge clock);
		arstN <= 1'b1;
		sendOp(mkOp(opMovIr, aluAdd, predAlways, 6'd18, '0, '0, imm), 1'b0, 6'd18, signExt(imm), 1'b1);
		drain();
		checkValue("tFlag", 64'(tFlag), 64'd0);
		reportTest("reset", errBefore);
	endtask

	// Writeback monitor, sampled away from the driving edge
	always @(negedge clock) begin
		if (arstN) begin
			if (expQ.size() != 0 && expQ[0].due == cyc) begin
				checkValue("wbValid", 64'(wbValid), 64'd1);
				checkValue("wbOut.rdId", 64'(wbOut.rdId), 64'(expQ[0].rdId));
				if (expQ[0].chkVal)
					checkValue("wbOut.value", wbOut.value, expQ[0].value);
				expQ.delete(0);
			end else begin
				checkValue("wbValid", 64'(wbValid), 64'd0); // Nothing due
			end
		end
		cyc = cyc + 32'd1;
	end

	initial begin
		#((plannedOps + marginCycles) * clockPeriod);
		$display("Timeout: the tests did not finish in the expected number of cycles");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		clock       = 1'b0;
		arstN       = 1'b0;
		issueValid  = 1'b0;
		issueOp     = '0;
		braFlush    = 1'b0;
		cyc         = '0;
		lcgState    = 64'd48061;
		modelT      = 1'b0;
		errCount    = 0;
		checkCount  = 0;
		testCount   = 0;
		passedTests = 0;
		repeat (2) @(posedge clock);
		arstN <= 1'b1;
		testAlu();
		testPred();
		testMem();
		testFlush();
		testReset();
		$display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
			passedTests, testCount, checkCount, errCount);
		if (errCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+logic
logic/laneOpPkg.sv
logic/laneStagePkg.sv
logic/laneExec1.sv
logic/laneExec2.sv
logic/laneDataMem.sv
logic/laneExec3.sv
logic/laneExecTop.sv
verif/laneExec_chk.sv
verif/laneExecTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = laneExecTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)
